//--- csr_top.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_excp_encode.sv
hw/csr_access.sv
hw/csr_mode_regs.sv
hw/csr_timer.sv
hw/csr_top.sv
test/csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, then run the testbench binary

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f csr_top.f --top-module csr_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vcsr_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0

//--- test/csr_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_tb;
  import csr_pkg::*;

  localparam int K_WRITE     = 0;
  localparam int K_WRITE_INT = 1;
  localparam int K_STALL_WR  = 2;
  localparam int K_READ      = 3;
  localparam int K_EXCP      = 4;
  localparam int K_ERTN      = 5;
  localparam int K_WAIT_INT  = 6;
  localparam int K_HOLD_INT  = 7;
  localparam int K_RDID      = 8;
  localparam int K_CNT       = 9;

  localparam logic [31:0] FULL      = 32'hffff_ffff;
  localparam logic [31:0] EXC_PC    = 32'h1c00_0104;
  localparam logic [31:0] EXC_VADDR = 32'h0000_2003;

  logic                   clk, rst_n, csr_we_i, stall_i, ertn_i, commit_i, int_o;
  logic [`CSR_ADDR_W-1:0] csr_r_addr_i, csr_w_addr_i;
  logic [`CSR_XLEN-1:0]   csr_w_mask_i, csr_w_data_i, pc_i, vaddr_i;
  logic [`CSR_XLEN-1:0]   csr_r_data_o, crmd_o, era_o, eentry_o;
  logic [`EXCP_W-1:0]     excp_i;
  logic [7:0]             int_i;
  rdcnt_e                 rdcnt_i;

  // stimulus table, one entry per step
  int                     kind_q[$];
  logic [`CSR_ADDR_W-1:0] addr_q[$];
  logic [31:0]            mask_q[$];
  logic [31:0]            data_q[$];
  logic [31:0]            exp_q[$];
  string                  name_q[$];
  logic [31:0]            cnt_prev;

  csr_top u_dut (.clk, .rst_n, .csr_r_addr_i, .rdcnt_i, .csr_we_i, .csr_w_addr_i,
    .csr_w_mask_i, .csr_w_data_i, .stall_i, .excp_i, .pc_i, .vaddr_i, .ertn_i,
    .commit_i, .int_i, .csr_r_data_o, .int_o, .crmd_o, .era_o, .eentry_o);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (actv !== expv) begin
      $display("Fail %s expected %h actual %h", name, expv, actv);
      abort_run("value mismatch");
    end
  endtask

  task automatic add_step(input int kind, input logic [`CSR_ADDR_W-1:0] addr,
                          input logic [31:0] mask, input logic [31:0] data,
                          input logic [31:0] expv, input string name);
    kind_q.push_back(kind);
    addr_q.push_back(addr);
    mask_q.push_back(mask);
    data_q.push_back(data);
    exp_q.push_back(expv);
    name_q.push_back(name);
  endtask

  task automatic run_step(input int i);
    int waited;
    case (kind_q[i])
      K_WRITE, K_WRITE_INT, K_STALL_WR: begin
        @(posedge clk);
        csr_we_i     <= 1'b1;
        csr_w_addr_i <= addr_q[i];
        csr_w_mask_i <= mask_q[i];
        csr_w_data_i <= data_q[i];
        stall_i      <= (kind_q[i] == K_STALL_WR);
        @(negedge clk);
        // forwarded interrupt seen while the write is in flight
        if (kind_q[i] == K_WRITE_INT) begin
          compare(name_q[i], exp_q[i], {31'b0, int_o});
        end
        @(posedge clk);
        csr_we_i <= 1'b0;
        stall_i  <= 1'b0;
      end
      K_READ, K_RDID, K_CNT: begin
        @(posedge clk);
        csr_r_addr_i <= addr_q[i];
        if (kind_q[i] == K_RDID) begin
          rdcnt_i <= RDCNT_ID;
        end else if (kind_q[i] == K_CNT) begin
          rdcnt_i <= RDCNT_VLOW;
        end else begin
          rdcnt_i <= RDCNT_NONE;
        end
        @(posedge clk);
        @(negedge clk);
        if (kind_q[i] == K_CNT) begin
          compare(name_q[i], 32'd1, {31'b0, csr_r_data_o > cnt_prev});
          cnt_prev = csr_r_data_o;
        end else begin
          compare(name_q[i], exp_q[i], csr_r_data_o & mask_q[i]);
        end
        // direct register outputs match the value read back
        if (kind_q[i] == K_READ) begin
          case (addr_q[i])
            CSR_CRMD:   compare({name_q[i], "_port"}, exp_q[i], crmd_o & mask_q[i]);
            CSR_ERA:    compare({name_q[i], "_port"}, exp_q[i], era_o & mask_q[i]);
            CSR_EENTRY: compare({name_q[i], "_port"}, exp_q[i], eentry_o & mask_q[i]);
            default: ;
          endcase
        end
      end
      K_EXCP: begin
        @(posedge clk);
        excp_i  <= data_q[i][`EXCP_W-1:0];
        pc_i    <= EXC_PC;
        vaddr_i <= EXC_VADDR;
        @(posedge clk);
        excp_i <= '0;
      end
      K_ERTN: begin
        @(posedge clk);
        ertn_i <= 1'b1;
        @(posedge clk);
        ertn_i <= 1'b0;
      end
      K_WAIT_INT: begin
        waited = 0;
        @(negedge clk);
        while (int_o !== exp_q[i][0] && waited < int'(data_q[i])) begin
          @(negedge clk);
          waited++;
        end
        if (int_o !== exp_q[i][0]) begin
          abort_run("int_o did not reach the expected level in time");
        end
      end
      default: begin
        for (int n = 0; n < int'(data_q[i]); n++) begin
          @(negedge clk);
          compare(name_q[i], exp_q[i], {31'b0, int_o});
        end
      end
    endcase
  endtask

  initial begin
    logic [31:0]            rng;
    logic [31:0]            save_v [4];
    logic [31:0]            tid_v;
    logic [`CSR_ADDR_W-1:0] save_addr;
    rst_n        <= 1'b0;
    csr_we_i     <= 1'b0;
    stall_i      <= 1'b0;
    ertn_i       <= 1'b0;
    commit_i     <= 1'b1;
    csr_r_addr_i <= '0;
    csr_w_addr_i <= '0;
    csr_w_mask_i <= '0;
    csr_w_data_i <= '0;
    pc_i         <= '0;
    vaddr_i      <= '0;
    excp_i       <= '0;
    int_i        <= '0;
    rdcnt_i      <= RDCNT_NONE;
    cnt_prev     = '0;
    rng          = 32'h4253_bfce;

    add_step(K_READ, CSR_CRMD, FULL, 0, 32'h8, "crmd_reset");
    add_step(K_READ, CSR_ESTAT, FULL, 0, 0, "estat_reset");
    add_step(K_HOLD_INT, '0, 0, 1, 0, "int_reset");
    save_addr = CSR_SAVE0;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      save_v[i] = rng;
      add_step(K_WRITE, save_addr, FULL, rng, 0, "save_wr");
      add_step(K_READ, save_addr, FULL, 0, rng, $sformatf("save%0d_rd", i));
      save_addr = save_addr + 14'd1;
    end
    rng = xorshift32(rng);
    tid_v = rng;
    add_step(K_WRITE, CSR_TID, FULL, tid_v, 0, "tid_wr");
    add_step(K_READ, CSR_TID, FULL, 0, tid_v, "tid_rd");
    add_step(K_WRITE, CSR_CRMD, FULL, FULL, 0, "crmd_wr_ones");
    add_step(K_READ, CSR_CRMD, FULL, 0, 32'h1ff, "crmd_rd_ones");
    add_step(K_WRITE, CSR_EENTRY, FULL, FULL, 0, "eentry_wr");
    add_step(K_READ, CSR_EENTRY, FULL, 0, 32'hffff_ffc0, "eentry_rd");
    // masked write merges with the value just read
    add_step(K_READ, CSR_SAVE1, FULL, 0, save_v[1], "save1_pre");
    add_step(K_WRITE, CSR_SAVE1, 32'h0000_ffff, 32'h1234_5678, 0, "save1_masked");
    add_step(K_READ, CSR_SAVE1, FULL, 0, {save_v[1][31:16], 16'h5678}, "save1_merged");
    add_step(K_STALL_WR, CSR_SAVE2, FULL, ~save_v[2], 0, "save2_stalled");
    add_step(K_READ, CSR_SAVE2, FULL, 0, save_v[2], "save2_kept");

    // plv 3 with ie set, then an ale exception
    add_step(K_WRITE, CSR_CRMD, FULL, 32'hf, 0, "crmd_plv3");
    add_step(K_EXCP, '0, 0, 32'd1 << EXCP_ALE, 0, "excp_ale");
    add_step(K_READ, CSR_ERA, FULL, 0, EXC_PC, "era_pc");
    add_step(K_READ, CSR_BADV, FULL, 0, EXC_VADDR, "badv_vaddr");
    add_step(K_READ, CSR_ESTAT, 32'h003f_0000, 0, 32'h0009_0000, "estat_ecode_ale");
    add_step(K_READ, CSR_CRMD, 32'h7, 0, 0, "crmd_after_excp");
    add_step(K_READ, CSR_PRMD, FULL, 0, 32'h7, "prmd_saved");
    add_step(K_ERTN, '0, 0, 0, 0, "ertn");
    add_step(K_READ, CSR_CRMD, 32'h7, 0, 32'h7, "crmd_after_ertn");
    add_step(K_EXCP, '0, 0,
             (32'd1 << EXCP_ADEM) | (32'd1 << EXCP_SYS) | (32'd1 << EXCP_BRK), 0, "excp_multi");
    // ade with esubcode 1
    add_step(K_READ, CSR_ESTAT, 32'h7fff_0000, 0, 32'h0048_0000, "estat_priority");
    add_step(K_ERTN, '0, 0, 0, 0, "ertn");
    add_step(K_READ, CSR_CRMD, 32'h7, 0, 32'h7, "crmd_after_ertn2");

    add_step(K_WRITE, CSR_ECTL, FULL, 32'h1, 0, "ectl_sw0");
    add_step(K_WRITE_INT, CSR_ESTAT, FULL, 32'h1, 1, "int_sw_fwd");
    add_step(K_HOLD_INT, '0, 0, 2, 1, "int_sw_held");
    add_step(K_WRITE, CSR_CRMD, FULL, 32'hb, 0, "crmd_ie_off");
    add_step(K_HOLD_INT, '0, 0, 2, 0, "int_ie_off");
    add_step(K_WRITE, CSR_CRMD, FULL, 32'hf, 0, "crmd_ie_on");
    add_step(K_HOLD_INT, '0, 0, 1, 1, "int_ie_on");
    add_step(K_WRITE_INT, CSR_ESTAT, FULL, 32'h0, 0, "int_sw_clear");
    add_step(K_HOLD_INT, '0, 0, 2, 0, "int_sw_low");

    // one-shot timer, initval 4
    add_step(K_WRITE, CSR_ECTL, FULL, 32'h800, 0, "ectl_ti");
    add_step(K_WRITE, CSR_TCFG, FULL, (32'd4 << 2) | 32'h1, 0, "tcfg_oneshot");
    add_step(K_WAIT_INT, '0, 0, 40, 1, "int_timer");
    add_step(K_READ, CSR_ESTAT, 32'h800, 0, 32'h800, "estat_ti");
    add_step(K_WRITE_INT, CSR_TICLR, FULL, 32'h1, 0, "ticlr_fwd");
    add_step(K_HOLD_INT, '0, 0, 40, 0, "int_timer_cleared");

    add_step(K_RDID, CSR_CRMD, FULL, 0, tid_v, "rdcnt_id");
    add_step(K_CNT, CSR_CRMD, FULL, 0, 0, "cnt_first");
    add_step(K_HOLD_INT, '0, 0, 4, 0, "cnt_gap");
    add_step(K_CNT, CSR_CRMD, FULL, 0, 0, "cnt_second");

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < kind_q.size(); i++) begin
      run_step(i);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/csr_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CSR_ADDR_W-1:0] csr_r_addr_i,
  input  csr_pkg::rdcnt_e        rdcnt_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [`CSR_XLEN-1:0]   csr_w_mask_i,
  input  logic [`CSR_XLEN-1:0]   csr_w_data_i,
  input  logic                   stall_i,
  input  logic [`EXCP_W-1:0]     excp_i,
  input  logic [`CSR_XLEN-1:0]   pc_i,
  input  logic [`CSR_XLEN-1:0]   vaddr_i,
  input  logic                   ertn_i,
  input  logic                   commit_i,
  input  logic [7:0]             int_i,
  output logic [`CSR_XLEN-1:0]   csr_r_data_o,
  output logic                   int_o,
  output logic [`CSR_XLEN-1:0]   crmd_o,
  output logic [`CSR_XLEN-1:0]   era_o,
  output logic [`CSR_XLEN-1:0]   eentry_o
);
  import csr_pkg::*;

  logic                   excp_valid, addr_err, wr_en, timer_is;
  ecode_e                 ecode;
  logic [8:0]             esubcode;
  logic [`CSR_ADDR_W-1:0] wr_addr;
  logic [`CSR_XLEN-1:0]   wr_data, mode_rdata, timer_rdata, tid;
  logic [63:0]            counter;

  csr_excp_encode u_excp (.excp_i, .excp_valid_o(excp_valid), .addr_err_o(addr_err),
    .ecode_o(ecode), .esubcode_o(esubcode));

  csr_access u_access (.clk, .rst_n, .stall_i, .csr_we_i, .csr_w_addr_i, .csr_w_mask_i,
    .csr_w_data_i, .csr_r_addr_i, .rdcnt_i, .mode_rdata_i(mode_rdata),
    .timer_rdata_i(timer_rdata), .tid_i(tid), .counter_i(counter), .wr_en_o(wr_en),
    .wr_addr_o(wr_addr), .wr_data_o(wr_data), .csr_r_data_o);

  csr_mode_regs u_mode (.clk, .rst_n, .wr_en_i(wr_en), .wr_addr_i(wr_addr),
    .wr_data_i(wr_data), .rd_addr_i(csr_r_addr_i), .excp_valid_i(excp_valid),
    .addr_err_i(addr_err), .ecode_i(ecode), .esubcode_i(esubcode), .excp_pc_i(pc_i),
    .vaddr_i, .adef_i(excp_i[EXCP_ADEF]), .ertn_i, .commit_i, .int_i,
    .timer_is_i(timer_is), .rdata_o(mode_rdata), .tid_o(tid), .crmd_o, .era_o,
    .eentry_o, .int_o);

  csr_timer u_timer (.clk, .rst_n, .wr_en_i(wr_en), .wr_addr_i(wr_addr),
    .wr_data_i(wr_data), .rd_addr_i(csr_r_addr_i), .commit_i, .rdata_o(timer_rdata),
    .timer_is_o(timer_is), .counter_o(counter));

endmodule

`default_nettype wire

//--- hw/csr_timer.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_timer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en_i,
  input  logic [`CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [`CSR_XLEN-1:0]   wr_data_i,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic                   commit_i,
  output logic [`CSR_XLEN-1:0]   rdata_o,
  output logic                   timer_is_o,
  output logic [63:0]            counter_o
);
  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] tcfg_q, tval_q, reload_val;
  logic [63:0]          counter_q;
  logic                 timer_en_q, ti_q, timer_evt_q;
  logic                 tcfg_we, ticlr_clr, tval_reload;

  assign tcfg_we     = wr_en_i && wr_addr_i == CSR_TCFG;
  assign ticlr_clr   = wr_en_i && wr_addr_i == CSR_TICLR && wr_data_i[`TICLR_CLR];
  assign tval_reload = timer_en_q && tval_q == '0 && commit_i;
  assign reload_val  = tcfg_q[`TCFG_PERIODIC] ? {tcfg_q[`TCFG_INITVAL], 2'b0} : `TVAL_ONESHOT_END;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q      <= '0;
      tval_q      <= '0;
      counter_q   <= '0;
      timer_en_q  <= 1'b0;
      ti_q        <= 1'b0;
      timer_evt_q <= 1'b0;
    end else begin
      counter_q   <= counter_q + 64'd1;
      // event one cycle after tval reaches one or zero
      timer_evt_q <= timer_en_q && (tval_q == 32'd1 || tval_q == 32'd0);
      if (tcfg_we) begin
        tcfg_q <= wr_data_i;
      end
      if (ticlr_clr) begin
        ti_q <= 1'b0;
      end else if (tcfg_we) begin
        timer_en_q <= wr_data_i[`TCFG_EN];
      end else if (timer_evt_q && commit_i) begin
        ti_q       <= 1'b1;
        timer_en_q <= tcfg_q[`TCFG_PERIODIC];
      end
      if (tcfg_we) begin
        tval_q <= {wr_data_i[`TCFG_INITVAL], 2'b0};
      end else if (timer_en_q && tval_q != '0) begin
        tval_q <= tval_q - 32'd1;
      end else if (tval_reload) begin
        tval_q <= reload_val;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (rd_addr_i)
      CSR_TCFG:  rdata_o = tcfg_q;
      CSR_TVAL:  rdata_o = tval_q;
      CSR_ESTAT: rdata_o[`ESTAT_TI] = ti_q;
      default:   rdata_o = '0;
    endcase
  end

  assign timer_is_o = ticlr_clr ? 1'b0 : (timer_evt_q || ti_q);
  assign counter_o  = counter_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    (!tcfg_we && !tval_reload) |=> tval_q <= $past(tval_q));

endmodule

`default_nettype wire

//--- hw/csr_mode_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_mode_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en_i,
  input  logic [`CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [`CSR_XLEN-1:0]   wr_data_i,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic                   excp_valid_i,
  input  logic                   addr_err_i,
  input  csr_pkg::ecode_e        ecode_i,
  input  logic [8:0]             esubcode_i,
  input  logic [`CSR_XLEN-1:0]   excp_pc_i,
  input  logic [`CSR_XLEN-1:0]   vaddr_i,
  input  logic                   adef_i,
  input  logic                   ertn_i,
  input  logic                   commit_i,
  input  logic [7:0]             int_i,
  input  logic                   timer_is_i,
  output logic [`CSR_XLEN-1:0]   rdata_o,
  output logic [`CSR_XLEN-1:0]   tid_o,
  output logic [`CSR_XLEN-1:0]   crmd_o,
  output logic [`CSR_XLEN-1:0]   era_o,
  output logic [`CSR_XLEN-1:0]   eentry_o,
  output logic                   int_o
);
  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] crmd_q, era_q, badv_q, tid_q, estat_rd;
  logic [2:0]           prmd_q;
  logic [`ECTL_LIE]     ectl_q;
  logic [`EENTRY_VA]    eentry_q;
  logic [`CSR_XLEN-1:0] save_q [4];
  logic [1:0]           soft_q, soft_fwd;
  logic [7:0]           int_q, hw_q;
  ecode_e               ecode_q;
  logic [8:0]           esub_q;
  logic [`ESTAT_IS]     is_fwd;
  logic                 crmd_we, prmd_we, ectl_we, estat_we, save_we;

  assign crmd_we  = wr_en_i && wr_addr_i == CSR_CRMD;
  assign prmd_we  = wr_en_i && wr_addr_i == CSR_PRMD;
  assign ectl_we  = wr_en_i && wr_addr_i == CSR_ECTL;
  assign estat_we = wr_en_i && wr_addr_i == CSR_ESTAT;
  assign save_we  = wr_en_i && wr_addr_i >= CSR_SAVE0 && wr_addr_i <= CSR_SAVE3;

  // later assignments win, so a write beats ertn beats an exception
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q  <= `CRMD_RESET;
      prmd_q  <= '0;
      ectl_q  <= '0;
      soft_q  <= '0;
      hw_q    <= '0;
      ecode_q <= ECODE_INT;
      esub_q  <= '0;
    end else begin
      if (commit_i) begin
        hw_q <= int_q;
      end
      if (excp_valid_i) begin
        prmd_q[`PRMD_PPLV] <= crmd_q[`CRMD_PLV];
        prmd_q[`PRMD_PIE]  <= crmd_q[`CRMD_IE];
        crmd_q[`CRMD_PLV]  <= 2'b0;
        crmd_q[`CRMD_IE]   <= 1'b0;
        ecode_q            <= ecode_i;
        esub_q             <= esubcode_i;
      end
      if (ertn_i) begin
        crmd_q[`CRMD_PLV] <= prmd_q[`PRMD_PPLV];
        crmd_q[`CRMD_IE]  <= prmd_q[`PRMD_PIE];
      end
      if (crmd_we) begin
        crmd_q[`CRMD_PLV]  <= wr_data_i[`CRMD_PLV];
        crmd_q[`CRMD_IE]   <= wr_data_i[`CRMD_IE];
        crmd_q[`CRMD_DA]   <= wr_data_i[`CRMD_DA];
        crmd_q[`CRMD_PG]   <= wr_data_i[`CRMD_PG];
        crmd_q[`CRMD_DATF] <= wr_data_i[`CRMD_DATF];
        crmd_q[`CRMD_DATM] <= wr_data_i[`CRMD_DATM];
      end
      if (prmd_we) begin
        prmd_q[`PRMD_PPLV] <= wr_data_i[`PRMD_PPLV];
        prmd_q[`PRMD_PIE]  <= wr_data_i[`PRMD_PIE];
      end
      if (ectl_we) begin
        ectl_q <= {wr_data_i[12:11], 1'b0, wr_data_i[9:0]};
      end
      if (estat_we) begin
        soft_q <= wr_data_i[1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    int_q <= int_i;
    if (excp_valid_i) begin
      era_q <= excp_pc_i;
    end
    if (addr_err_i) begin
      badv_q <= adef_i ? excp_pc_i : vaddr_i;
    end
    if (wr_en_i && wr_addr_i == CSR_ERA) begin
      era_q <= wr_data_i;
    end
    if (wr_en_i && wr_addr_i == CSR_BADV) begin
      badv_q <= wr_data_i;
    end
    if (wr_en_i && wr_addr_i == CSR_EENTRY) begin
      eentry_q <= wr_data_i[`EENTRY_VA];
    end
    if (save_we) begin
      save_q[wr_addr_i[1:0]] <= wr_data_i;
    end
    if (wr_en_i && wr_addr_i == CSR_TID) begin
      tid_q <= wr_data_i;
    end
  end

  // ti comes from the timer block and is ORed in later
  always_comb begin
    estat_rd                  = '0;
    estat_rd[`ESTAT_ESUBCODE] = esub_q;
    estat_rd[`ESTAT_ECODE]    = ecode_q;
    estat_rd[9:0]             = {hw_q, soft_q};
  end

  always_comb begin
    rdata_o = '0;
    case (rd_addr_i)
      CSR_CRMD:   rdata_o = crmd_q;
      CSR_PRMD:   rdata_o[2:0] = prmd_q;
      CSR_ECTL:   rdata_o[`ECTL_LIE] = ectl_q;
      CSR_ESTAT:  rdata_o = estat_rd;
      CSR_ERA:    rdata_o = era_q;
      CSR_BADV:   rdata_o = badv_q;
      CSR_EENTRY: rdata_o[`EENTRY_VA] = eentry_q;
      CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: rdata_o = save_q[rd_addr_i[1:0]];
      CSR_TID:    rdata_o = tid_q;
      default:    rdata_o = '0;
    endcase
  end

  // software bits forwarded from a write in flight
  assign soft_fwd = estat_we ? wr_data_i[1:0] : soft_q;

  always_comb begin
    is_fwd            = '0;
    is_fwd[1:0]       = soft_fwd;
    is_fwd[9:2]       = int_q;
    is_fwd[`ESTAT_TI] = timer_is_i;
  end

  assign int_o    = crmd_q[`CRMD_IE] && |(is_fwd & ectl_q);
  assign tid_o    = tid_q;
  assign crmd_o   = crmd_q;
  assign era_o    = era_q;
  assign eentry_o = {eentry_q, 6'b0};

  assert property (@(posedge clk) disable iff (!rst_n) !(excp_valid_i && ertn_i));

endmodule

`default_nettype wire

//--- hw/csr_access.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_access (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall_i,
  input  logic                   csr_we_i,
  input  logic [`CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [`CSR_XLEN-1:0]   csr_w_mask_i,
  input  logic [`CSR_XLEN-1:0]   csr_w_data_i,
  input  logic [`CSR_ADDR_W-1:0] csr_r_addr_i,
  input  csr_pkg::rdcnt_e        rdcnt_i,
  input  logic [`CSR_XLEN-1:0]   mode_rdata_i,
  input  logic [`CSR_XLEN-1:0]   timer_rdata_i,
  input  logic [`CSR_XLEN-1:0]   tid_i,
  input  logic [63:0]            counter_i,
  output logic                   wr_en_o,
  output logic [`CSR_ADDR_W-1:0] wr_addr_o,
  output logic [`CSR_XLEN-1:0]   wr_data_o,
  output logic [`CSR_XLEN-1:0]   csr_r_data_o
);
  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] rd_sel;

  // merge against the value read back for the same instruction
  assign wr_en_o   = csr_we_i && !stall_i;
  assign wr_addr_o = csr_w_addr_i;
  assign wr_data_o = (csr_r_data_o & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);

  always_comb begin
    case (rdcnt_i)
      RDCNT_ID:    rd_sel = tid_i;
      RDCNT_VLOW:  rd_sel = counter_i[31:0];
      RDCNT_VHIGH: rd_sel = counter_i[63:32];
      default:     rd_sel = mode_rdata_i | timer_rdata_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!stall_i) begin
      csr_r_data_o <= rd_sel;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) wr_en_o |-> !$isunknown(wr_addr_o));

  // a plain csr read needs a defined address in both register blocks
  assert property (@(posedge clk) disable iff (!rst_n)
    (!stall_i && rdcnt_i == RDCNT_NONE) |-> !$isunknown(csr_r_addr_i));

endmodule

`default_nettype wire

//--- hw/csr_excp_encode.sv
`default_nettype none
`timescale 1ns/100ps
`include "csr_consts.svh"

module csr_excp_encode (
  input  logic [`EXCP_W-1:0] excp_i,
  output logic               excp_valid_o,
  output logic               addr_err_o,
  output csr_pkg::ecode_e    ecode_o,
  output logic [8:0]         esubcode_o
);
  import csr_pkg::*;

  assign excp_valid_o = |excp_i;

  always_comb begin
    ecode_o    = ECODE_INT;
    esubcode_o = '0;
    addr_err_o = 1'b0;
    if (excp_i[EXCP_INT]) begin
      ecode_o = ECODE_INT;
    end else if (excp_i[EXCP_ADEF]) begin
      ecode_o    = ECODE_ADE;
      addr_err_o = 1'b1;
    end else if (excp_i[EXCP_ADEM]) begin
      ecode_o    = ECODE_ADE;
      esubcode_o = 9'd1;
      addr_err_o = 1'b1;
    end else if (excp_i[EXCP_ALE]) begin
      ecode_o    = ECODE_ALE;
      addr_err_o = 1'b1;
    end else if (excp_i[EXCP_SYS]) begin
      ecode_o = ECODE_SYS;
    end else if (excp_i[EXCP_BRK]) begin
      ecode_o = ECODE_BRK;
    end else if (excp_i[EXCP_INE]) begin
      ecode_o = ECODE_INE;
    end else if (excp_i[EXCP_IPE]) begin
      ecode_o = ECODE_IPE;
    end
  end

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none
`include "csr_consts.svh"

package csr_pkg;

  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_CRMD   = 14'h000,
    CSR_PRMD   = 14'h001,
    CSR_ECTL   = 14'h004,
    CSR_ESTAT  = 14'h005,
    CSR_ERA    = 14'h006,
    CSR_BADV   = 14'h007,
    CSR_EENTRY = 14'h00c,
    CSR_SAVE0  = 14'h030,
    CSR_SAVE1  = 14'h031,
    CSR_SAVE2  = 14'h032,
    CSR_SAVE3  = 14'h033,
    CSR_TID    = 14'h040,
    CSR_TCFG   = 14'h041,
    CSR_TVAL   = 14'h042,
    CSR_TICLR  = 14'h044
  } csr_addr_e;

  // position in the flag vector, first entry wins
  typedef enum int unsigned {
    EXCP_INT, EXCP_ADEF, EXCP_ADEM, EXCP_ALE,
    EXCP_SYS, EXCP_BRK, EXCP_INE, EXCP_IPE
  } excp_bit_e;

  typedef enum logic [5:0] {
    ECODE_INT = 6'h0,
    ECODE_ADE = 6'h8,
    ECODE_ALE = 6'h9,
    ECODE_SYS = 6'hb,
    ECODE_BRK = 6'hc,
    ECODE_INE = 6'hd,
    ECODE_IPE = 6'he
  } ecode_e;

  typedef enum logic [1:0] {RDCNT_NONE, RDCNT_ID, RDCNT_VLOW, RDCNT_VHIGH} rdcnt_e;

endpackage

`default_nettype wire

//--- hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 14
`define EXCP_W     8

// crmd fields
`define CRMD_PLV   1:0
`define CRMD_IE    2
`define CRMD_DA    3
`define CRMD_PG    4
`define CRMD_DATF  6:5
`define CRMD_DATM  8:7
`define CRMD_RESET 32'h8

`define PRMD_PPLV 1:0
`define PRMD_PIE  2

// local interrupt enables, bit 10 reserved
`define ECTL_LIE 12:0

`define ESTAT_IS       12:0
`define ESTAT_TI       11
`define ESTAT_ECODE    21:16
`define ESTAT_ESUBCODE 30:22

`define EENTRY_VA 31:6

`define TCFG_EN       0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL  31:2
`define TICLR_CLR     0

`define TVAL_ONESHOT_END 32'hffff_ffff

`endif
